// File: hdl/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

	localparam int DBG_ADDR_W = 8;
	localparam int DBG_DATA_W = 32;

	localparam logic [DBG_DATA_W-1:0] DBG_IDCODE   = 32'h1DEB0A5F;
	localparam logic [DBG_DATA_W-1:0] DBG_BAD_READ = 32'hDEADBEEF;

	// Register map
	localparam logic [DBG_ADDR_W-1:0] ADDR_PRBS_CTRL  = 8'h00;
	localparam logic [DBG_ADDR_W-1:0] ADDR_PRBS_EQN   = 8'h01;
	localparam logic [DBG_ADDR_W-1:0] ADDR_SCRATCH    = 8'h02;
	localparam logic [DBG_ADDR_W-1:0] ADDR_ERR_BITS   = 8'h10;
	localparam logic [DBG_ADDR_W-1:0] ADDR_TOTAL_BITS = 8'h11;
	localparam logic [DBG_ADDR_W-1:0] ADDR_STATUS     = 8'h12;

	// PRBS_CTRL fields
	localparam int CTRL_GEN_CKE = 0;
	localparam int CTRL_CHK_CKE = 1;
	localparam int CTRL_INJ_ERR = 2;
	localparam int CTRL_CLEAR   = 3;

	localparam int PRBS_LOCK_LEN = 16;
	localparam int PRBS_MAX_LEN  = 15;

	typedef enum logic [3:0] {
		TEST_LOGIC_RESET, RUN_TEST_IDLE,
		SELECT_DR, CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR, UPDATE_DR,
		SELECT_IR, CAPTURE_IR, SHIFT_IR, EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
	} jtag_state_e;

	typedef enum logic [3:0] {
		IDCODE    = 4'h1,
		REG_ADDR  = 4'h2,
		REG_WRITE = 4'h3,
		REG_READ  = 4'h4,
		BYPASS    = 4'hF
	} jtag_opcode_e;

	typedef enum logic {
		PRBS7  = 1'b0,
		PRBS15 = 1'b1
	} prbs_eqn_e;

endpackage

`default_nettype wire

// File: hdl/reg_bus_intf.sv
`default_nettype none

interface reg_bus_intf;
	import dbg_pkg::*;

	logic [DBG_ADDR_W-1:0] addr;
	logic [DBG_DATA_W-1:0] wdata;
	logic                  wr_en;
	logic [DBG_DATA_W-1:0] rdata;

	modport master (
		output addr,
		output wdata,
		output wr_en,
		input  rdata
	);

	modport slave (
		input  addr,
		input  wdata,
		input  wr_en,
		output rdata
	);
endinterface

`default_nettype wire

// File: hdl/prbs_debug_intf.sv
`default_nettype none

interface prbs_debug_intf;
	import dbg_pkg::*;

	// Configuration from the register file
	logic      gen_cke;
	logic      chk_cke;
	prbs_eqn_e eqn;
	logic      inj_err;
	logic      clear;

	// Checker results
	logic [DBG_DATA_W-1:0] err_bits;
	logic [DBG_DATA_W-1:0] total_bits;
	logic                  locked;

	modport jtag (
		output gen_cke, chk_cke, eqn, inj_err, clear,
		input  err_bits, total_bits, locked
	);

	modport core (
		input  gen_cke, chk_cke, eqn, inj_err, clear,
		output err_bits, total_bits, locked
	);
endinterface

`default_nettype wire

// File: hdl/jtag_tap.sv
`default_nettype none

module jtag_tap (
	input  logic clk,
	input  logic rst_n_i,
	input  logic tck_i,
	input  logic tms_i,
	input  logic tdi_i,
	input  logic trst_n_i,
	output logic tdo_o,
	reg_bus_intf.master bus_o
);
	import dbg_pkg::*;

	logic [3:0] pins_q1;
	logic [3:0] pins_q2;
	logic tck_d;
	logic tck;
	logic tms;
	logic tdi;
	logic tck_rise;
	logic tck_fall;
	logic tap_rst;

	jtag_state_e state_q;
	jtag_state_e state_d;
	logic [3:0] ir_q;
	logic [3:0] ir_sr_q;
	jtag_opcode_e op;
	logic [DBG_DATA_W-1:0] dr_q;
	logic upd_dr;

	// Two-flop synchronizer on the JTAG pins, oversampled by clk
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pins_q1 <= 4'b1000;
			pins_q2 <= 4'b1000;
			tck_d   <= 1'b0;
		end else begin
			pins_q1 <= {trst_n_i, tdi_i, tms_i, tck_i};
			pins_q2 <= pins_q1;
			tck_d   <= pins_q2[0];
		end
	end

	assign tck      = pins_q2[0];
	assign tms      = pins_q2[1];
	assign tdi      = pins_q2[2];
	assign tck_rise = tck & ~tck_d;
	assign tck_fall = ~tck & tck_d;
	assign tap_rst  = !rst_n_i || !pins_q2[3];

	// Unknown opcodes fall back to bypass
	always_comb begin
		case (ir_q)
			IDCODE, REG_ADDR, REG_WRITE, REG_READ: op = jtag_opcode_e'(ir_q);
			default: op = BYPASS;
		endcase
	end

	always_comb begin
		case (state_q)
			TEST_LOGIC_RESET: state_d = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
			RUN_TEST_IDLE:    state_d = tms ? SELECT_DR : RUN_TEST_IDLE;
			SELECT_DR:        state_d = tms ? SELECT_IR : CAPTURE_DR;
			CAPTURE_DR:       state_d = tms ? EXIT1_DR : SHIFT_DR;
			SHIFT_DR:         state_d = tms ? EXIT1_DR : SHIFT_DR;
			EXIT1_DR:         state_d = tms ? UPDATE_DR : PAUSE_DR;
			PAUSE_DR:         state_d = tms ? EXIT2_DR : PAUSE_DR;
			EXIT2_DR:         state_d = tms ? UPDATE_DR : SHIFT_DR;
			UPDATE_DR:        state_d = tms ? SELECT_DR : RUN_TEST_IDLE;
			SELECT_IR:        state_d = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
			CAPTURE_IR:       state_d = tms ? EXIT1_IR : SHIFT_IR;
			SHIFT_IR:         state_d = tms ? EXIT1_IR : SHIFT_IR;
			EXIT1_IR:         state_d = tms ? UPDATE_IR : PAUSE_IR;
			PAUSE_IR:         state_d = tms ? EXIT2_IR : PAUSE_IR;
			EXIT2_IR:         state_d = tms ? UPDATE_IR : SHIFT_IR;
			UPDATE_IR:        state_d = tms ? SELECT_DR : RUN_TEST_IDLE;
			default:          state_d = TEST_LOGIC_RESET;
		endcase
	end

	assign upd_dr = tck_rise && (state_d == UPDATE_DR);

	always_ff @(posedge clk) begin
		if (tap_rst) begin
			state_q     <= TEST_LOGIC_RESET;
			ir_q        <= IDCODE;
			tdo_o       <= 1'b0;
			bus_o.addr  <= '0;
			bus_o.wr_en <= 1'b0;
		end else begin
			bus_o.wr_en <= upd_dr && (op == REG_WRITE);
			if (tck_rise) begin
				state_q <= state_d;
				if (state_d == TEST_LOGIC_RESET)
					ir_q <= IDCODE;
				else if (state_d == UPDATE_IR)
					ir_q <= ir_sr_q;
				if (upd_dr && op == REG_ADDR)
					bus_o.addr <= dr_q[DBG_ADDR_W-1:0];
			end else if (tck_fall) begin
				case (state_q)
					SHIFT_DR: tdo_o <= dr_q[0];
					SHIFT_IR: tdo_o <= ir_sr_q[0];
					default:  tdo_o <= 1'b0;
				endcase
			end
		end
	end

	// Shift paths, length set by the active opcode
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			if (state_q == CAPTURE_DR) begin
				case (op)
					IDCODE:   dr_q <= DBG_IDCODE;
					REG_ADDR: dr_q <= {{(DBG_DATA_W-DBG_ADDR_W){1'b0}}, bus_o.addr};
					REG_READ: dr_q <= bus_o.rdata;
					default:  dr_q <= '0;
				endcase
			end else if (state_q == SHIFT_DR) begin
				case (op)
					IDCODE, REG_WRITE, REG_READ: dr_q <= {tdi, dr_q[DBG_DATA_W-1:1]};
					REG_ADDR: dr_q[DBG_ADDR_W-1:0] <= {tdi, dr_q[DBG_ADDR_W-1:1]};
					default:  dr_q[0] <= tdi;
				endcase
			end
			if (state_q == CAPTURE_IR)
				ir_sr_q <= 4'b0101;
			else if (state_q == SHIFT_IR)
				ir_sr_q <= {tdi, ir_sr_q[3:1]};
		end
		if (upd_dr && op == REG_WRITE)
			bus_o.wdata <= dr_q;
	end

	wr_en_single_cycle: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		bus_o.wr_en |=> !bus_o.wr_en
	);

endmodule

`default_nettype wire

// File: hdl/dbg_reg_file.sv
`default_nettype none

module dbg_reg_file (
	input logic clk,
	input logic rst_n_i,
	reg_bus_intf.slave bus_i,
	prbs_debug_intf.jtag prbs_o
);
	import dbg_pkg::*;

	logic gen_cke_q;
	logic chk_cke_q;
	prbs_eqn_e eqn_q;
	logic inj_err_q;
	logic clear_q;
	logic [DBG_DATA_W-1:0] scratch_q;
	logic wr_ctrl;

	assign wr_ctrl = bus_i.wr_en && (bus_i.addr == ADDR_PRBS_CTRL);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			gen_cke_q <= 1'b0;
			chk_cke_q <= 1'b0;
			eqn_q     <= PRBS7;
			inj_err_q <= 1'b0;
			clear_q   <= 1'b0;
		end else begin
			// One-shot controls last a single cycle
			inj_err_q <= wr_ctrl && bus_i.wdata[CTRL_INJ_ERR];
			clear_q   <= wr_ctrl && bus_i.wdata[CTRL_CLEAR];
			if (wr_ctrl) begin
				gen_cke_q <= bus_i.wdata[CTRL_GEN_CKE];
				chk_cke_q <= bus_i.wdata[CTRL_CHK_CKE];
			end
			if (bus_i.wr_en && bus_i.addr == ADDR_PRBS_EQN)
				eqn_q <= prbs_eqn_e'(bus_i.wdata[0]);
		end
	end

	always_ff @(posedge clk) begin
		if (bus_i.wr_en && bus_i.addr == ADDR_SCRATCH)
			scratch_q <= bus_i.wdata;
	end

	assign prbs_o.gen_cke = gen_cke_q;
	assign prbs_o.chk_cke = chk_cke_q;
	assign prbs_o.eqn     = eqn_q;
	assign prbs_o.inj_err = inj_err_q;
	assign prbs_o.clear   = clear_q;

	// Read mux
	always_comb begin
		case (bus_i.addr)
			ADDR_PRBS_CTRL: begin
				bus_i.rdata = '0;
				bus_i.rdata[CTRL_GEN_CKE] = gen_cke_q;
				bus_i.rdata[CTRL_CHK_CKE] = chk_cke_q;
			end
			ADDR_PRBS_EQN:   bus_i.rdata = {{(DBG_DATA_W-1){1'b0}}, eqn_q};
			ADDR_SCRATCH:    bus_i.rdata = scratch_q;
			ADDR_ERR_BITS:   bus_i.rdata = prbs_o.err_bits;
			ADDR_TOTAL_BITS: bus_i.rdata = prbs_o.total_bits;
			ADDR_STATUS:     bus_i.rdata = {{(DBG_DATA_W-1){1'b0}}, prbs_o.locked};
			default:         bus_i.rdata = DBG_BAD_READ;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/prbs_gen.sv
`default_nettype none

module prbs_gen (
	input  logic clk,
	input  logic rst_n_i,
	prbs_debug_intf.core prbs_i,
	output logic prbs_bit_o
);
	import dbg_pkg::*;

	logic [PRBS_MAX_LEN-1:0] lfsr_q;
	logic fb;

	always_comb begin
		case (prbs_i.eqn)
			PRBS15: fb = lfsr_q[14] ^ lfsr_q[13];
			// Escape the all-zero state left behind by a switch from PRBS15
			default: fb = (lfsr_q[6] ^ lfsr_q[5]) | (lfsr_q[6:0] == 7'd0);
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			lfsr_q     <= '1;
			prbs_bit_o <= 1'b0;
		end else if (prbs_i.gen_cke) begin
			lfsr_q     <= {lfsr_q[PRBS_MAX_LEN-2:0], fb};
			// Injected error flips the output only, not the LFSR
			prbs_bit_o <= fb ^ prbs_i.inj_err;
		end
	end

endmodule

`default_nettype wire

// File: hdl/prbs_checker.sv
`default_nettype none

module prbs_checker (
	input logic clk,
	input logic rst_n_i,
	prbs_debug_intf.core prbs_i,
	input logic prbs_bit_i
);
	import dbg_pkg::*;

	logic [PRBS_MAX_LEN-1:0] hist_q;
	logic [$clog2(PRBS_LOCK_LEN)-1:0] match_cnt_q;
	logic [DBG_DATA_W-1:0] err_bits_q;
	logic [DBG_DATA_W-1:0] total_bits_q;
	logic locked_q;
	logic predicted;
	logic mismatch;

	// Prediction from received history
	always_comb begin
		case (prbs_i.eqn)
			PRBS15:  predicted = hist_q[14] ^ hist_q[13];
			default: predicted = hist_q[6] ^ hist_q[5];
		endcase
	end

	assign mismatch = prbs_bit_i ^ predicted;

	always_ff @(posedge clk) begin
		if (prbs_i.chk_cke)
			hist_q <= {hist_q[PRBS_MAX_LEN-2:0], prbs_bit_i};
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || prbs_i.clear) begin
			match_cnt_q  <= '0;
			locked_q     <= 1'b0;
			err_bits_q   <= '0;
			total_bits_q <= '0;
		end else if (prbs_i.chk_cke) begin
			if (locked_q) begin
				// Saturating counters
				if (total_bits_q != '1)
					total_bits_q <= total_bits_q + 1'b1;
				if (mismatch && err_bits_q != '1)
					err_bits_q <= err_bits_q + 1'b1;
			end else if (mismatch) begin
				match_cnt_q <= '0;
			end else if (int'(match_cnt_q) == PRBS_LOCK_LEN - 1) begin
				locked_q <= 1'b1;
			end else begin
				match_cnt_q <= match_cnt_q + 1'b1;
			end
		end
	end

	assign prbs_i.err_bits   = err_bits_q;
	assign prbs_i.total_bits = total_bits_q;
	assign prbs_i.locked     = locked_q;

	err_le_total: assert property (
		@(posedge clk) disable iff (!rst_n_i)
		prbs_i.err_bits <= prbs_i.total_bits
	);

endmodule

`default_nettype wire

// File: hdl/debug_top.sv
`default_nettype none

module debug_top (
	input  logic clk,
	input  logic rst_n_i,
	input  logic tck_i,
	input  logic tms_i,
	input  logic tdi_i,
	input  logic trst_n_i,
	output logic tdo_o
);

	reg_bus_intf reg_bus ();
	prbs_debug_intf prbs_dbg ();

	logic prbs_bit;

	jtag_tap u_jtag_tap (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.tck_i    (tck_i),
		.tms_i    (tms_i),
		.tdi_i    (tdi_i),
		.trst_n_i (trst_n_i),
		.tdo_o    (tdo_o),
		.bus_o    (reg_bus.master)
	);

	dbg_reg_file u_dbg_reg_file (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.bus_i   (reg_bus.slave),
		.prbs_o  (prbs_dbg.jtag)
	);

	prbs_gen u_prbs_gen (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.prbs_i     (prbs_dbg.core),
		.prbs_bit_o (prbs_bit)
	);

	prbs_checker u_prbs_checker (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.prbs_i     (prbs_dbg.core),
		.prbs_bit_i (prbs_bit)
	);

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o;
	end

	// Reset held low for three clock cycles
	initial begin
		rst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/tb_debug_top.sv
`default_nettype none

module tb_debug_top;
	import dbg_pkg::*;

	localparam logic [31:0] EXP_IDCODE   = 32'h1DEB0A5F;
	localparam logic [31:0] EXP_BAD_READ = 32'hDEADBEEF;
	localparam logic [31:0] RAND_SEED    = 32'h931ae99a;

	logic clk;
	logic rst_n;
	logic tck;
	logic tms;
	logic tdi;
	logic trst_n;
	logic tdo;

	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int test_base = 0;
	logic [31:0] rand_state = RAND_SEED;

	tb_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	debug_top u_debug_top (
		.clk      (clk),
		.rst_n_i  (rst_n),
		.tck_i    (tck),
		.tms_i    (tms),
		.tdi_i    (tdi),
		.trst_n_i (trst_n),
		.tdo_o    (tdo)
	);

	// TDO comes out of reset low
	tdo_low_after_reset: assert property (@(posedge clk) !rst_n |=> tdo == 1'b0)
		else begin
			$display("[FAIL] tdo_o expected 0x0 got 0x%0h after reset", tdo);
			error_count++;
		end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("[FAIL] %s expected 0x%08h got 0x%08h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic start_test();
		test_base = error_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (error_count == test_base) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: FAILED", name);
			failed_tests++;
		end
	endtask

	// One TCK period, low half then high half, 4 clk cycles each
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(posedge clk);
		tck <= 1'b0;
		tms <= tms_v;
		tdi <= tdi_v;
		repeat (3) @(posedge clk);
		@(negedge clk);
		tdo_v = tdo;
		@(posedge clk);
		tck <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic tap_reset();
		logic unused;
		repeat (5) tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	// Starts and ends in Run-Test-Idle
	task automatic shift_ir(input logic [3:0] ir);
		logic unused;
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (int i = 0; i < 4; i++)
			tck_cycle(i == 3, ir[i], unused);
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic shift_dr(input int len, input logic [31:0] din, output logic [31:0] dout);
		logic unused;
		logic bit_out;
		dout = '0;
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, unused);
		tck_cycle(1'b0, 1'b0, unused);
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		shift_ir(REG_ADDR);
		shift_dr(8, {24'h0, addr}, unused);
		shift_ir(REG_WRITE);
		shift_dr(32, data, unused);
	endtask

	task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
		logic [31:0] unused;
		shift_ir(REG_ADDR);
		shift_dr(8, {24'h0, addr}, unused);
		shift_ir(REG_READ);
		shift_dr(32, 32'h0, data);
	endtask

	// Polls STATUS until bit 0 is set
	task automatic wait_for_lock(input string tag);
		logic [31:0] status;
		logic got_lock;
		got_lock = 1'b0;
		for (int i = 0; i < 20 && !got_lock; i++) begin
			reg_read(ADDR_STATUS, status);
			got_lock = status[0];
		end
		assert (got_lock)
		else begin
			$display("timeout: %s checker never reported lock", tag);
			error_count++;
		end
	endtask

	task automatic prbs_test(input logic eqn, input string tag);
		logic [31:0] rd;
		logic [31:0] first;
		logic [31:0] exp_err;
		exp_err = 32'h0;
		reg_write(ADDR_PRBS_CTRL, 32'h9);
		reg_write(ADDR_PRBS_EQN, {31'h0, eqn});
		reg_write(ADDR_PRBS_CTRL, 32'h3);
		wait_for_lock(tag);
		reg_read(ADDR_ERR_BITS, rd);
		check_value("err_bits", 32'h0, rd);
		reg_read(ADDR_TOTAL_BITS, first);
		reg_read(ADDR_TOTAL_BITS, rd);
		assert (first != 32'h0 && rd > first)
		else begin
			$display("[FAIL] total_bits expected to grow, got 0x%08h then 0x%08h", first, rd);
			error_count++;
		end
		// One flipped bit costs three errors
		repeat (2) begin
			reg_write(ADDR_PRBS_CTRL, 32'h7);
			exp_err += 32'd3;
			reg_read(ADDR_ERR_BITS, rd);
			check_value("err_bits", exp_err, rd);
		end
		reg_write(ADDR_PRBS_CTRL, 32'h9);
		reg_read(ADDR_ERR_BITS, rd);
		check_value("err_bits", 32'h0, rd);
		reg_read(ADDR_TOTAL_BITS, rd);
		check_value("total_bits", 32'h0, rd);
		reg_read(ADDR_STATUS, rd);
		check_value("status[0]", 32'h0, rd & 32'h1);
		reg_write(ADDR_PRBS_CTRL, 32'h3);
		wait_for_lock(tag);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] pattern;
		logic unused;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		trst_n = 1'b1;
		for (int i = 0; i < 20 && rst_n !== 1'b1; i++)
			@(posedge clk);
		assert (rst_n === 1'b1)
		else begin
			$display("timeout: reset was never released");
			error_count++;
		end

		start_test();
		tck_cycle(1'b0, 1'b0, unused);
		shift_dr(32, 32'h0, rd);
		check_value("idcode", EXP_IDCODE, rd);
		end_test("idcode_after_reset");

		start_test();
		shift_ir(BYPASS);
		tap_reset();
		shift_dr(32, 32'h0, rd);
		check_value("idcode", EXP_IDCODE, rd);
		end_test("idcode_after_tms_reset");

		start_test();
		shift_ir(BYPASS);
		rand_state = next_random(rand_state);
		pattern = rand_state;
		shift_dr(32, pattern, rd);
		check_value("bypass tdo", pattern << 1, rd);
		end_test("bypass");

		start_test();
		shift_ir(4'h7);
		rand_state = next_random(rand_state);
		pattern = rand_state;
		shift_dr(32, pattern, rd);
		check_value("unused opcode tdo", pattern << 1, rd);
		end_test("unused_opcode");

		start_test();
		repeat (4) begin
			rand_state = next_random(rand_state);
			reg_write(ADDR_SCRATCH, rand_state);
			reg_read(ADDR_SCRATCH, rd);
			check_value("scratch", rand_state, rd);
		end
		end_test("scratch");

		start_test();
		reg_read(8'h55, rd);
		check_value("unmapped read", EXP_BAD_READ, rd);
		end_test("unmapped_read");

		start_test();
		reg_write(ADDR_ERR_BITS, 32'h1234_5678);
		reg_read(ADDR_ERR_BITS, rd);
		check_value("err_bits", 32'h0, rd);
		end_test("err_bits_read_only");

		start_test();
		reg_write(ADDR_PRBS_CTRL, 32'hF);
		reg_read(ADDR_PRBS_CTRL, rd);
		check_value("prbs_ctrl", 32'h3, rd);
		reg_write(ADDR_PRBS_CTRL, 32'hC);
		reg_read(ADDR_PRBS_CTRL, rd);
		check_value("prbs_ctrl", 32'h0, rd);
		end_test("prbs_ctrl_readback");

		start_test();
		prbs_test(1'b0, "prbs7");
		end_test("prbs7");

		start_test();
		prbs_test(1'b1, "prbs15");
		end_test("prbs15");

		$display("%0d tests run, %0d failed, %0d check errors",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
hdl/dbg_pkg.sv
hdl/reg_bus_intf.sv
hdl/prbs_debug_intf.sv
hdl/jtag_tap.sv
hdl/dbg_reg_file.sv
hdl/prbs_gen.sv
hdl/prbs_checker.sv
hdl/debug_top.sv
bench/tb_clk_gen.sv
bench/tb_debug_top.sv

// File: Bender.yml
package:
  name: debug_top

sources:
  - hdl/dbg_pkg.sv
  - hdl/reg_bus_intf.sv
  - hdl/prbs_debug_intf.sv
  - hdl/jtag_tap.sv
  - hdl/dbg_reg_file.sv
  - hdl/prbs_gen.sv
  - hdl/prbs_checker.sv
  - hdl/debug_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_debug_top.sv
